/* design/mgr_cfg_pkg.sv */
// Configuration port request type and register map of the work-unit manager
`default_nettype none

package mgr_cfg_pkg;

  localparam int CFG_ADDR_W = 10;
  localparam int CFG_DATA_W = 32;

  // One write per cycle while valid is high
  typedef struct packed {
    logic                  valid;
    logic [CFG_ADDR_W-1:0] addr;
    logic [CFG_DATA_W-1:0] data;
  } cfg_req_t;

  // ------------------------------------------------------------------------
  // Register map

  localparam logic [CFG_ADDR_W-1:0] CFG_CTRL_ADDR  = 10'd0;    // Bit 0 starts a run
  localparam logic [CFG_ADDR_W-1:0] CFG_START_ADDR = 10'd1;    // First instruction index
  localparam logic [CFG_ADDR_W-1:0] CFG_IMEM_BASE  = 10'd512;  // Bit 9 selects WU memory

endpackage

`default_nettype wire

/* design/mgr_wu_pkg.sv */
// Work-unit instruction, OOB packet and lane request types for the manager pipeline
`default_nettype none

package mgr_wu_pkg;

  localparam int WU_ADDR_W = 20;                  // Lane read address width
  localparam int WU_LEN_W  = 10;                  // Lane word count width

  // Instruction opcode in the top two bits of every word
  typedef enum logic [1:0] {
    NOP = 2'd0,                                   // Skipped by fetch
    OP  = 2'd1,                                   // PE configuration
    MR  = 2'd2,                                   // Memory read descriptor
    END = 2'd3                                    // Stops the run
  } wu_op_e;

  typedef struct packed {
    logic [7:0] tag;                              // Matches returning data to the WU
    logic [5:0] num_lanes;
    logic [7:0] stop_cmd;                         // Stack operation command
    logic [7:0] simd_cmd;
  } wu_op_fields_t;

  typedef struct packed {
    logic [WU_ADDR_W-1:0] addr;                   // First lane word
    logic [WU_LEN_W-1:0]  len;                    // Lane words, at least one
  } wu_mr_fields_t;

  // Same 30 bits read as OP or MR depending on the opcode
  typedef union packed {
    wu_op_fields_t op;
    wu_mr_fields_t mr;
  } wu_payload_u;

  typedef struct packed {
    wu_op_e      opcode;
    wu_payload_u payload;
  } wu_instr_t;

  typedef wu_op_fields_t oob_pkt_t;               // OOB carries the OP fields as is

  typedef struct packed {
    logic [WU_ADDR_W-1:0] addr;
    logic                 last;                   // Final word of a descriptor
  } lane_req_t;

endpackage

`default_nettype wire

/* design/mgr_cfg_regs.sv */
// Configuration registers of the manager, decoding the cfg port into run control and memory writes
`timescale 1ns/1ps
`default_nettype none

module mgr_cfg_regs
  import mgr_cfg_pkg::*, mgr_wu_pkg::*;
#(
  parameter  int IMEM_DEPTH = 256,
  localparam int IDX_W      = $clog2(IMEM_DEPTH)
)
(
  input  logic             clk,
  input  logic             arst_n,
  input  cfg_req_t         cfg,
  input  logic             done,          // End of fetch
  output logic             busy,
  output logic             go,
  output logic [IDX_W-1:0] start_addr,
  output logic             imem_we,
  output logic [IDX_W-1:0] imem_addr,
  output wu_instr_t        imem_data
);

  logic ctrl_hit;
  logic start_hit;
  logic imem_hit;

  // ------------------------------------------------------------------------
  // Address decode

  assign ctrl_hit  = cfg.valid && (cfg.addr == CFG_CTRL_ADDR);
  assign start_hit = cfg.valid && (cfg.addr == CFG_START_ADDR);
  assign imem_hit  = cfg.valid && (cfg.addr >= CFG_IMEM_BASE);    // Upper half of the map

  // Start only from idle
  assign go = ctrl_hit && cfg.data[0] && !busy;

  // Program writes locked out for the whole run
  assign imem_we   = imem_hit && !busy;
  assign imem_addr = cfg.addr[IDX_W-1:0];     // Entry index below the base bit
  assign imem_data = wu_instr_t'(cfg.data);

  // ------------------------------------------------------------------------
  // Run flag and start address

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      busy       <= 1'b0;
      start_addr <= '0;
    end
    else
    begin
      if (go)
        busy <= 1'b1;
      else if (done)
        busy <= 1'b0;                       // Outputs may still be draining

      // Sampled by fetch only on go
      if (start_hit)
        start_addr <= cfg.data[IDX_W-1:0];
    end
  end

endmodule

`default_nettype wire

/* design/wu_fetch.sv */
// Work-unit memory and fetch sequencer, streams OP and MR words to the decoder
`timescale 1ns/1ps
`default_nettype none

module wu_fetch
  import mgr_wu_pkg::*;
#(
  parameter  int IMEM_DEPTH = 256,
  localparam int IDX_W      = $clog2(IMEM_DEPTH)
)
(
  input  logic             clk,
  input  logic             arst_n,
  input  logic             go,
  input  logic [IDX_W-1:0] start_addr,
  input  logic             imem_we,
  input  logic [IDX_W-1:0] imem_addr,
  input  wu_instr_t        imem_data,
  output logic             done,
  output logic             instr_valid,
  input  logic             instr_ready,
  output wu_instr_t        instr
);

  wu_instr_t        mem [IMEM_DEPTH];
  wu_instr_t        rd_word;            // Read stage word
  logic             rd_vld;
  logic             running;
  logic [IDX_W-1:0] fetch_addr;
  logic             advance;
  logic             end_hit;
  logic             rd_en;
  logic             fwd;

  // Whole pipe freezes while the output is held
  assign advance = !instr_valid || instr_ready;
  assign end_hit = rd_vld && (rd_word.opcode == END);
  assign rd_en   = running && advance && !end_hit;    // Nothing read past END
  assign fwd     = rd_vld && (rd_word.opcode == OP || rd_word.opcode == MR);

  // ------------------------------------------------------------------------
  // WU memory with registered read

  always_ff @(posedge clk)
  begin
    if (imem_we)
      mem[imem_addr] <= imem_data;
    if (rd_en)
      rd_word <= mem[fetch_addr];
  end

  // ------------------------------------------------------------------------
  // Fetch sequencer

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      running    <= 1'b0;
      fetch_addr <= '0;
      rd_vld     <= 1'b0;
      done       <= 1'b0;
    end
    else
    begin
      done <= advance && end_hit;               // One cycle, END leaves the read stage
      if (go)
      begin
        running    <= 1'b1;
        fetch_addr <= start_addr;
        rd_vld     <= 1'b0;
      end
      else if (advance)
      begin
        if (end_hit)
          running <= 1'b0;
        rd_vld <= rd_en;
        if (rd_en)
          fetch_addr <= fetch_addr + 1'b1;    // Wraps at IMEM_DEPTH
      end
    end
  end

  // ------------------------------------------------------------------------
  // Output register, NOP and END dropped here

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      instr_valid <= 1'b0;
    else if (advance)
      instr_valid <= fwd;
  end

  always_ff @(posedge clk)
  begin
    if (advance && fwd)
      instr <= rd_word;
  end

endmodule

`default_nettype wire

/* design/wu_decode.sv */
// Instruction router, turns OP words into OOB packets and MR words into read descriptors
`timescale 1ns/1ps
`default_nettype none

module wu_decode
  import mgr_wu_pkg::*;
(
  input  logic          clk,
  input  logic          arst_n,
  input  logic          instr_valid,
  output logic          instr_ready,
  input  wu_instr_t     instr,
  output logic          oob_valid,
  input  logic          oob_ready,
  output oob_pkt_t      oob_pkt,
  output logic          desc_valid,
  input  logic          desc_ready,
  output wu_mr_fields_t desc
);

  wu_payload_u payload;
  logic        is_op;
  logic        is_mr;
  logic        oob_free;
  logic        desc_free;
  logic        load_op;
  logic        load_mr;

  assign payload = instr.payload;
  assign is_op   = (instr.opcode == OP);
  assign is_mr   = (instr.opcode == MR);

  // Target register empty or emptying this cycle
  assign oob_free  = !oob_valid || oob_ready;
  assign desc_free = !desc_valid || desc_ready;

  // Only the targeted path can stall, OP may overtake a blocked MR
  assign instr_ready = is_op ? oob_free : (is_mr ? desc_free : 1'b1);

  assign load_op = instr_valid && is_op && oob_free;
  assign load_mr = instr_valid && is_mr && desc_free;

  // ------------------------------------------------------------------------
  // OOB output register

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      oob_valid <= 1'b0;
    else if (load_op)
      oob_valid <= 1'b1;
    else if (oob_ready)
      oob_valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (load_op)
      oob_pkt <= payload.op;                  // Fields pass unchanged
  end

  // ------------------------------------------------------------------------
  // Read descriptor register

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      desc_valid <= 1'b0;
    else if (load_mr)
      desc_valid <= 1'b1;
    else if (desc_ready)
      desc_valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (load_mr)
      desc <= payload.mr;                     // Same bits seen as addr and len
  end

endmodule

`default_nettype wire

/* design/mrc_cntl.sv */
// Memory read controller, expands one descriptor into sequential lane read addresses
`timescale 1ns/1ps
`default_nettype none

module mrc_cntl
  import mgr_wu_pkg::*;
(
  input  logic          clk,
  input  logic          arst_n,
  input  logic          desc_valid,
  output logic          desc_ready,
  input  wu_mr_fields_t desc,
  output logic          lane_valid,
  input  logic          lane_ready,
  output lane_req_t     lane_req
);

  logic [WU_LEN_W-1:0] cnt;               // Words left after the current one
  logic                xfer;
  logic                accept;

  assign xfer = lane_valid && lane_ready;

  // Idle, or handing over the final word this cycle
  assign desc_ready = !lane_valid || (lane_ready && lane_req.last);
  assign accept     = desc_valid && desc_ready;

  // ------------------------------------------------------------------------
  // Lane request stream

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      lane_valid <= 1'b0;
    else if (accept)
      lane_valid <= 1'b1;
    else if (xfer && lane_req.last)
      lane_valid <= 1'b0;                 // Descriptor finished
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      lane_req.addr <= desc.addr;
      lane_req.last <= (desc.len <= 1);   // Single word descriptor
      cnt           <= desc.len - 1'b1;
    end
    else if (xfer)
    begin
      lane_req.addr <= lane_req.addr + 1'b1;
      lane_req.last <= (cnt == 1);
      cnt           <= cnt - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* design/wu_manager.sv */
// Work-unit manager top level, config block feeding fetch, decode and memory read stages
`timescale 1ns/1ps
`default_nettype none

module wu_manager
  import mgr_cfg_pkg::*, mgr_wu_pkg::*;
#(
  parameter  int IMEM_DEPTH = 256,        // Power of two up to 512
  localparam int IDX_W      = $clog2(IMEM_DEPTH)
)
(
  input  logic      clk,
  input  logic      arst_n,
  input  cfg_req_t  cfg,
  output logic      busy,
  output logic      oob_valid,            // Stack down OOB
  input  logic      oob_ready,
  output oob_pkt_t  oob_pkt,
  output logic      lane_valid,           // Lane read addresses
  input  logic      lane_ready,
  output lane_req_t lane_req
);

  // ------------------------------------------------------------------------
  // Config to fetch

  logic             go;
  logic             done;
  logic [IDX_W-1:0] start_addr;
  logic             imem_we;
  logic [IDX_W-1:0] imem_addr;
  wu_instr_t        imem_data;

  mgr_cfg_regs #(.IMEM_DEPTH(IMEM_DEPTH)) mgr_cfg_regs_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .cfg        (cfg),
    .done       (done),
    .busy       (busy),
    .go         (go),
    .start_addr (start_addr),
    .imem_we    (imem_we),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data)
  );

  // ------------------------------------------------------------------------
  // Fetch to decode to MRC

  logic          instr_valid;
  logic          instr_ready;
  wu_instr_t     instr;
  logic          desc_valid;
  logic          desc_ready;
  wu_mr_fields_t desc;

  wu_fetch #(.IMEM_DEPTH(IMEM_DEPTH)) wu_fetch_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .go          (go),
    .start_addr  (start_addr),
    .imem_we     (imem_we),
    .imem_addr   (imem_addr),
    .imem_data   (imem_data),
    .done        (done),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .instr       (instr)
  );

  wu_decode wu_decode_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .instr       (instr),
    .oob_valid   (oob_valid),     // Straight to the OOB port
    .oob_ready   (oob_ready),
    .oob_pkt     (oob_pkt),
    .desc_valid  (desc_valid),
    .desc_ready  (desc_ready),
    .desc        (desc)
  );

  mrc_cntl mrc_cntl_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .desc_valid (desc_valid),
    .desc_ready (desc_ready),
    .desc       (desc),
    .lane_valid (lane_valid),
    .lane_ready (lane_ready),
    .lane_req   (lane_req)
  );

endmodule

`default_nettype wire

/* dv/wu_manager_props.sv */
// Handshake, reset and run-start properties of the manager, bound onto the top level
`timescale 1ns/1ps
`default_nettype none

module wu_manager_props
  import mgr_cfg_pkg::*, mgr_wu_pkg::*;
(
  input logic      clk,
  input logic      arst_n,
  input cfg_req_t  cfg,
  input logic      busy,
  input logic      oob_valid,
  input logic      oob_ready,
  input oob_pkt_t  oob_pkt,
  input logic      lane_valid,
  input logic      lane_ready,
  input lane_req_t lane_req
);

  int   fail_count = 0;                     // Polled by the testbench
  logic start_wr;

  assign start_wr = cfg.valid && (cfg.addr == CFG_CTRL_ADDR) && cfg.data[0];

  // ------------------------------------------------------------------------
  // Held outputs under back-pressure

  oob_hold: assert property (@(posedge clk) disable iff (!arst_n)
    oob_valid && !oob_ready |=> oob_valid && $stable(oob_pkt))
  else
  begin
    $error("OOB valid or packet changed while stalled");
    fail_count++;
  end

  lane_hold: assert property (@(posedge clk) disable iff (!arst_n)
    lane_valid && !lane_ready |=> lane_valid && $stable(lane_req))
  else
  begin
    $error("Lane valid or request changed while stalled");
    fail_count++;
  end

  // Quiet outputs in reset
  rst_quiet: assert property (@(posedge clk) !arst_n |-> !oob_valid && !lane_valid)
  else
  begin
    $error("Output valid high during reset");
    fail_count++;
  end

  // A run only begins from a control write
  busy_start: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(busy) |-> $past(start_wr))
  else
  begin
    $error("busy rose with no start write");
    fail_count++;
  end

endmodule

bind wu_manager wu_manager_props wu_manager_props_i (
  .clk        (clk),
  .arst_n     (arst_n),
  .cfg        (cfg),
  .busy       (busy),
  .oob_valid  (oob_valid),
  .oob_ready  (oob_ready),
  .oob_pkt    (oob_pkt),
  .lane_valid (lane_valid),
  .lane_ready (lane_ready),
  .lane_req   (lane_req)
);

`default_nettype wire

/* dv/wu_manager_tb.sv */
// Table-driven testbench of the manager that loads programs, runs them and scores both output streams
`timescale 1ns/1ps
`default_nettype none

module wu_manager_tb
  import mgr_cfg_pkg::*, mgr_wu_pkg::*;
();

  localparam int          DEPTH  = 256;
  localparam int          N_ROWS = 5;
  localparam logic [31:0] NOP_W  = 32'h0000_0000;
  localparam logic [31:0] END_W  = 32'hC000_0000;    // Opcode 3 with an unused payload

  logic      clk        = 1'b0;
  logic      arst_n     = 1'b0;
  cfg_req_t  cfg        = '0;
  logic      oob_ready  = 1'b0;
  logic      lane_ready = 1'b0;
  logic      busy;
  logic      oob_valid;
  oob_pkt_t  oob_pkt;
  logic      lane_valid;
  lane_req_t lane_req;

  logic [31:0] row_words [N_ROWS][8];      // Program image per row
  int          row_start [N_ROWS] = '{0, 5, 252, 30, 60};
  int          row_len   [N_ROWS] = '{8, 7, 7, 6, 8};
  int          row_poke  [N_ROWS] = '{-1, -1, -1, 4, -1};    // Word rewritten mid run
  logic [29:0] exp_oob [$];
  logic [20:0] exp_lane [$];               // {addr, last}
  logic [31:0] rnd = 32'h91fccf60;
  int          cycles = 0;
  int          limit = 0;

  wu_manager #(.IMEM_DEPTH(DEPTH)) wu_manager_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .cfg        (cfg),
    .busy       (busy),
    .oob_valid  (oob_valid),
    .oob_ready  (oob_ready),
    .oob_pkt    (oob_pkt),
    .lane_valid (lane_valid),
    .lane_ready (lane_ready),
    .lane_req   (lane_req)
  );

  always #4 clk = ~clk;

  // ------------------------------------------------------------------------
  // Word builders and reference model

  function automatic logic [31:0] op_word(input logic [7:0] tag, input logic [5:0] lanes,
                                          input logic [7:0] stop, input logic [7:0] simd);
    return {2'b01, tag, lanes, stop, simd};
  endfunction

  function automatic logic [31:0] mr_word(input logic [19:0] addr, input logic [9:0] len);
    return {2'b10, addr, len};
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Walks a row up to END as the fetch does
  task automatic queue_expected(input int r);
    logic [31:0] w;
    int          len;
    for (int k = 0; k < row_len[r]; k++)
    begin
      w = row_words[r][k];
      if (w[31:30] == 2'b11)
        break;
      if (w[31:30] == 2'b01)
        exp_oob.push_back(w[29:0]);                  // Fields unchanged
      else if (w[31:30] == 2'b10)
      begin
        len = int'(w[9:0]);
        for (int n = 0; n < len; n++)
          exp_lane.push_back({w[29:10] + n[19:0], n == len - 1});
      end
    end
  endtask

  // 40 cycles per word and one per lane word on top of a margin
  function automatic int cycle_limit();
    int sum;
    sum = 500;
    for (int r = 0; r < N_ROWS; r++)
      for (int k = 0; k < row_len[r]; k++)
      begin
        sum += 40;
        if (row_words[r][k][31:30] == 2'b10)
          sum += int'(row_words[r][k][9:0]);
      end
    return sum;
  endfunction

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Test FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  // ------------------------------------------------------------------------
  // Stimulus

  task automatic cfg_write(input logic [9:0] addr, input logic [31:0] data);
    cfg = '{valid: 1'b1, addr: addr, data: data};
    @(negedge clk);
  endtask

  task automatic run_row(input int r);
    for (int k = 0; k < row_len[r]; k++)
      cfg_write(CFG_IMEM_BASE | 10'((row_start[r] + k) % DEPTH), row_words[r][k]);
    cfg_write(CFG_START_ADDR, 32'(row_start[r]));
    queue_expected(r);
    cfg_write(CFG_CTRL_ADDR, 32'd1);
    assert (busy)
    else abort_run($sformatf("CHECK FAILED t=%0t: busy not raised by the start write", $time));
    if (row_poke[r] >= 0)                               // busy is already high here
      cfg_write(CFG_IMEM_BASE | 10'((row_start[r] + row_poke[r]) % DEPTH),
                op_word(8'hee, 6'd0, 8'hee, 8'hee));
    cfg = '0;
    while (busy || exp_oob.size() != 0 || exp_lane.size() != 0)
      @(negedge clk);
  endtask

  // Random back-pressure on about half the cycles of each output
  always @(negedge clk)
  begin
    rnd        = lcg_next(rnd);
    oob_ready  = rnd[31];
    lane_ready = rnd[30];
  end

  initial
  begin
    row_words[0] = '{op_word(8'h11, 6'd4, 8'h22, 8'h33), mr_word(20'h00100, 10'd3), NOP_W,
                     op_word(8'h12, 6'd8, 8'h01, 8'h02), mr_word(20'h00200, 10'd1), END_W,
                     op_word(8'hff, 6'd63, 8'hff, 8'hff), mr_word(20'h00999, 10'd5)};
    row_words[1] = '{NOP_W, NOP_W, mr_word(20'h03000, 10'd4),
                     op_word(8'h21, 6'd1, 8'h40, 8'h41), op_word(8'h22, 6'd2, 8'h50, 8'h51),
                     mr_word(20'h00010, 10'd2), END_W, NOP_W};
    row_words[2] = '{op_word(8'h31, 6'd3, 8'h60, 8'h61), mr_word(20'hfff00, 10'd5), NOP_W,
                     op_word(8'h32, 6'd5, 8'h62, 8'h63), mr_word(20'h0abcd, 10'd2),
                     op_word(8'h33, 6'd7, 8'h64, 8'h65), END_W, NOP_W};    // Wraps to 0
    row_words[3] = '{mr_word(20'h00400, 10'd6), op_word(8'h41, 6'd9, 8'h70, 8'h71),
                     op_word(8'h42, 6'd10, 8'h72, 8'h73), mr_word(20'h00500, 10'd2),
                     op_word(8'h43, 6'd11, 8'h74, 8'h75), END_W, NOP_W, NOP_W};
    row_words[4] = '{mr_word(20'h07000, 10'd12), op_word(8'h51, 6'd12, 8'h80, 8'h81),
                     op_word(8'h52, 6'd13, 8'h82, 8'h83), op_word(8'h53, 6'd14, 8'h84, 8'h85),
                     op_word(8'h54, 6'd15, 8'h86, 8'h87), mr_word(20'h08000, 10'd1),
                     op_word(8'h55, 6'd16, 8'h88, 8'h89), END_W};
    limit = cycle_limit();
    repeat (8) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    for (int r = 0; r < N_ROWS; r++)
      run_row(r);
    repeat (20) @(negedge clk);                         // Room for stray transfers
    if (wu_manager_i.wu_manager_props_i.fail_count == 0)
    begin
      $display("Test OK");
      $finish;
    end
    else
      abort_run("Bound property checker reported a failure");
  end

  // ------------------------------------------------------------------------
  // Scoreboards and watchdog

  always @(posedge clk)
  begin
    if (arst_n && oob_valid && oob_ready)
    begin
      assert (exp_oob.size() > 0)
      else abort_run($sformatf("CHECK FAILED t=%0t: OOB packet %h not expected", $time, oob_pkt));
      assert (oob_pkt == exp_oob[0])
      else abort_run($sformatf("CHECK FAILED t=%0t: OOB packet %h, expected %h",
                               $time, oob_pkt, exp_oob[0]));
      void'(exp_oob.pop_front());
    end
  end

  always @(posedge clk)
  begin
    if (arst_n && lane_valid && lane_ready)
    begin
      assert (exp_lane.size() > 0)
      else abort_run($sformatf("CHECK FAILED t=%0t: lane addr %h not expected",
                               $time, lane_req.addr));
      assert (lane_req == exp_lane[0])
      else abort_run($sformatf("CHECK FAILED t=%0t: lane addr %h last %b, expected %h last %b",
                               $time, lane_req.addr, lane_req.last,
                               exp_lane[0][20:1], exp_lane[0][0]));
      void'(exp_lane.pop_front());
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (limit != 0 && cycles >= limit)
      abort_run("Timeout: the programs did not finish within the cycle limit");
    else if (wu_manager_i.wu_manager_props_i.fail_count != 0)
      abort_run("Bound property checker reported a failure");
  end

endmodule

`default_nettype wire

/* wu_manager.f */
design/mgr_cfg_pkg.sv
design/mgr_wu_pkg.sv
design/mgr_cfg_regs.sv
design/wu_fetch.sv
design/wu_decode.sv
design/mrc_cntl.sv
design/wu_manager.sv
dv/wu_manager_props.sv
dv/wu_manager_tb.sv

/* Makefile */
# Verilator build and run of the work-unit manager testbench

VERILATOR ?= verilator
TOP       ?= wu_manager_tb
FILELIST  ?= wu_manager.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Test OK

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
